// ==== source/chmod_pkg.sv ====
package chmod_pkg;

    localparam int NUM_CHANNELS = 4;
    localparam int CHAN_SEL_WIDTH = $clog2(NUM_CHANNELS);
    localparam int SAMPLE_WIDTH = 16;
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_WIDTH - 1));
    localparam int PHASE_WIDTH = 12;
    localparam int TRIG_WIDTH = 18;
    localparam int TRIG_SHIFT = 17;
    localparam int PROD_WIDTH = SAMPLE_WIDTH + TRIG_WIDTH;
    // Guard bits for the channel sum
    localparam int SUM_WIDTH = SAMPLE_WIDTH + CHAN_SEL_WIDTH;
    localparam int WB_DATA_WIDTH = 32;

    // Quarter-wave cosine table with 64 steps per quadrant plus the end point
    localparam int TABLE_PHASE_WIDTH = 8;
    localparam int TABLE_INDEX_WIDTH = TABLE_PHASE_WIDTH - 2;
    localparam int TABLE_DEPTH = 2 ** TABLE_INDEX_WIDTH + 1;
    localparam string TABLE_FILE = "source/chmod_cos_table.mem";

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] inph;
        logic signed [SAMPLE_WIDTH-1:0] quad;
    } iq_sample_t;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [CHAN_SEL_WIDTH-1:0] adr;
        logic [WB_DATA_WIDTH-1:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                   valid;
        logic [PHASE_WIDTH-1:0] inc;
    } phase_load_t;

endpackage

// ==== source/chmod_dds.sv ====
`timescale 1ns/1ps

module chmod_dds (
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  logic                                    i_ready,
    input  chmod_pkg::phase_load_t                  i_phase_load,
    output logic signed [chmod_pkg::TRIG_WIDTH-1:0] o_cosine_data,
    output logic signed [chmod_pkg::TRIG_WIDTH-1:0] o_sine_data
);
    import chmod_pkg::*;

    logic signed [TRIG_WIDTH-1:0] cos_table [TABLE_DEPTH];
    logic [PHASE_WIDTH-1:0]       phase_inc;
    logic [PHASE_WIDTH-1:0]       phase_acc;
    logic [TABLE_PHASE_WIDTH-1:0] table_phase;
    logic [1:0]                   quadrant;
    logic [TABLE_INDEX_WIDTH-1:0] table_index;

    initial begin
        $readmemh(TABLE_FILE, cos_table);
    end

    // Full-period cosine from the quarter table
    function automatic logic signed [TRIG_WIDTH-1:0] fold_cosine(
        input logic [1:0]                   quarter,
        input logic [TABLE_INDEX_WIDTH-1:0] k
    );
        logic signed [TRIG_WIDTH-1:0] near_val;
        logic signed [TRIG_WIDTH-1:0] far_val;
        near_val = cos_table[k];
        far_val = cos_table[(TABLE_INDEX_WIDTH+1)'(TABLE_DEPTH - 1) - {1'b0, k}];
        case (quarter)
            2'd0:    fold_cosine = near_val;
            2'd1:    fold_cosine = -far_val;
            2'd2:    fold_cosine = -near_val;
            default: fold_cosine = far_val;
        endcase
    endfunction

    assign table_phase = phase_acc[PHASE_WIDTH-1 -: TABLE_PHASE_WIDTH];
    assign quadrant = table_phase[TABLE_PHASE_WIDTH-1 -: 2];
    assign table_index = table_phase[TABLE_INDEX_WIDTH-1:0];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase_inc <= '0;
            phase_acc <= '0;
            o_cosine_data <= '0;
            o_sine_data <= '0;
        end else begin
            // New increment counts from the next ready edge
            if (i_phase_load.valid) begin
                phase_inc <= i_phase_load.inc;
            end
            if (i_ready) begin
                phase_acc <= phase_acc + phase_inc;
                o_cosine_data <= fold_cosine(quadrant, table_index);
                // Sine is cosine one quadrant back
                o_sine_data <= fold_cosine(quadrant - 2'd1, table_index);
            end
        end
    end

endmodule

// ==== source/channel_modulator.sv ====
`timescale 1ns/1ps

module channel_modulator (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_ready,
    input  chmod_pkg::iq_sample_t  i_sample,
    input  chmod_pkg::phase_load_t i_phase_load,
    output chmod_pkg::iq_sample_t  o_sample
);
    import chmod_pkg::*;

    logic signed [TRIG_WIDTH-1:0]   dds_cosine_data;
    logic signed [TRIG_WIDTH-1:0]   dds_sine_data;

    logic signed [SAMPLE_WIDTH-1:0] inph_reg0;
    logic signed [SAMPLE_WIDTH-1:0] quad_reg0;
    logic signed [TRIG_WIDTH-1:0]   cos_reg0;
    logic signed [TRIG_WIDTH-1:0]   sin_reg0;

    logic signed [PROD_WIDTH-1:0]   inph_cos_reg1;
    logic signed [PROD_WIDTH-1:0]   inph_sin_reg1;
    logic signed [SAMPLE_WIDTH-1:0] quad_reg1;
    logic signed [TRIG_WIDTH-1:0]   cos_reg1;
    logic signed [TRIG_WIDTH-1:0]   sin_reg1;

    logic signed [PROD_WIDTH-1:0]   inph_cos_reg2;
    logic signed [PROD_WIDTH-1:0]   inph_sin_reg2;
    logic signed [PROD_WIDTH-1:0]   quad_cos_reg2;
    logic signed [PROD_WIDTH-1:0]   quad_sin_reg2;

    // One extra bit so the add and subtract cannot wrap
    logic signed [PROD_WIDTH:0]     inph_sum;
    logic signed [PROD_WIDTH:0]     quad_sum;

    chmod_dds u_chmod_dds (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_ready      (i_ready),
        .i_phase_load (i_phase_load),
        .o_cosine_data(dds_cosine_data),
        .o_sine_data  (dds_sine_data)
    );

    assign inph_sum = inph_cos_reg2 - quad_sin_reg2;
    assign quad_sum = inph_sin_reg2 + quad_cos_reg2;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            inph_reg0 <= '0;
            quad_reg0 <= '0;
            cos_reg0 <= '0;
            sin_reg0 <= '0;
            inph_cos_reg1 <= '0;
            inph_sin_reg1 <= '0;
            quad_reg1 <= '0;
            cos_reg1 <= '0;
            sin_reg1 <= '0;
            inph_cos_reg2 <= '0;
            inph_sin_reg2 <= '0;
            quad_cos_reg2 <= '0;
            quad_sin_reg2 <= '0;
            o_sample <= '0;
        end else if (i_ready) begin
            // Capture sample with the current oscillator output
            inph_reg0 <= i_sample.inph;
            quad_reg0 <= i_sample.quad;
            cos_reg0 <= dds_cosine_data;
            sin_reg0 <= dds_sine_data;
            // In-phase products first
            inph_cos_reg1 <= inph_reg0 * cos_reg0;
            inph_sin_reg1 <= inph_reg0 * sin_reg0;
            quad_reg1 <= quad_reg0;
            cos_reg1 <= cos_reg0;
            sin_reg1 <= sin_reg0;
            // Quadrature products one stage later
            inph_cos_reg2 <= inph_cos_reg1;
            inph_sin_reg2 <= inph_sin_reg1;
            quad_cos_reg2 <= quad_reg1 * cos_reg1;
            quad_sin_reg2 <= quad_reg1 * sin_reg1;
            // Scale down by the table amplitude, then truncate
            o_sample.inph <= inph_sum[TRIG_SHIFT +: SAMPLE_WIDTH];
            o_sample.quad <= quad_sum[TRIG_SHIFT +: SAMPLE_WIDTH];
        end
    end

endmodule

// ==== source/chmod_wb_regs.sv ====
`timescale 1ns/1ps

module chmod_wb_regs (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  chmod_pkg::wb_req_t     i_wb,
    output chmod_pkg::wb_rsp_t     o_wb,
    output chmod_pkg::phase_load_t o_phase_load [chmod_pkg::NUM_CHANNELS]
);
    import chmod_pkg::*;

    logic [PHASE_WIDTH-1:0]  inc_regs [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] load_strobe;
    logic                    bus_req;

    // New request only while no ack is out
    assign bus_req = i_wb.cyc && i_wb.stb && !o_wb.ack;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb <= '0;
            load_strobe <= '0;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                inc_regs[ch] <= '0;
            end
        end else begin
            o_wb.ack <= bus_req;
            if (bus_req && !i_wb.we) begin
                o_wb.dat <= WB_DATA_WIDTH'(inc_regs[i_wb.adr]);
            end
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                load_strobe[ch] <= bus_req && i_wb.we
                                   && (i_wb.adr == CHAN_SEL_WIDTH'(ch));
            end
            if (bus_req && i_wb.we) begin
                inc_regs[i_wb.adr] <= i_wb.dat[PHASE_WIDTH-1:0];
            end
        end
    end

    // Strobe lines up with the write ack
    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            o_phase_load[ch].valid = load_strobe[ch];
            o_phase_load[ch].inc = inc_regs[ch];
        end
    end

endmodule

// ==== source/chmod_combiner.sv ====
`timescale 1ns/1ps

module chmod_combiner (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_ready,
    input  chmod_pkg::iq_sample_t i_channels [chmod_pkg::NUM_CHANNELS],
    output chmod_pkg::iq_sample_t o_sample
);
    import chmod_pkg::*;

    logic signed [SUM_WIDTH-1:0] inph_sum;
    logic signed [SUM_WIDTH-1:0] quad_sum;

    function automatic logic signed [SAMPLE_WIDTH-1:0] saturate(
        input logic signed [SUM_WIDTH-1:0] value
    );
        if (value > SAMPLE_MAX) begin
            saturate = SAMPLE_WIDTH'(SAMPLE_MAX);
        end else if (value < SAMPLE_MIN) begin
            saturate = SAMPLE_WIDTH'(SAMPLE_MIN);
        end else begin
            saturate = SAMPLE_WIDTH'(value);
        end
    endfunction

    always_comb begin
        inph_sum = '0;
        quad_sum = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            inph_sum = inph_sum + i_channels[ch].inph;
            quad_sum = quad_sum + i_channels[ch].quad;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_sample <= '0;
        end else if (i_ready) begin
            o_sample.inph <= saturate(inph_sum);
            o_sample.quad <= saturate(quad_sum);
        end
    end

endmodule

// ==== source/chmod_top.sv ====
`timescale 1ns/1ps

module chmod_top (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  chmod_pkg::wb_req_t    i_wb,
    output chmod_pkg::wb_rsp_t    o_wb,
    input  chmod_pkg::iq_sample_t i_samples [chmod_pkg::NUM_CHANNELS],
    output logic                  o_ready,
    output chmod_pkg::iq_sample_t o_sample,
    input  logic                  i_ready
);
    import chmod_pkg::*;

    phase_load_t phase_load [NUM_CHANNELS];
    iq_sample_t  channel_samples [NUM_CHANNELS];

    // Upstream stalls together with downstream
    assign o_ready = i_ready;

    chmod_wb_regs u_chmod_wb_regs (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .o_phase_load(phase_load)
    );

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        channel_modulator u_channel_modulator (
            .i_clock     (i_clock),
            .i_reset     (i_reset),
            .i_ready     (i_ready),
            .i_sample    (i_samples[ch]),
            .i_phase_load(phase_load[ch]),
            .o_sample    (channel_samples[ch])
        );
    end

    chmod_combiner u_chmod_combiner (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_ready   (i_ready),
        .i_channels(channel_samples),
        .o_sample  (o_sample)
    );

endmodule

// ==== verif/chmod_sva.sv ====
`timescale 1ns/1ps

module chmod_sva (
    input logic                  i_clock,
    input logic                  i_reset,
    input logic                  i_ready,
    input logic                  o_ready,
    input chmod_pkg::wb_req_t    i_wb,
    input chmod_pkg::wb_rsp_t    o_wb,
    input chmod_pkg::iq_sample_t o_sample
);

    int failures = 0;

    ack_single_cycle: assert property (
        @(posedge i_clock) disable iff (i_reset) o_wb.ack |=> !o_wb.ack
    ) else begin
        $error("Wishbone ack stayed high for two cycles");
        failures++;
    end

    // Ack answers a request seen on the previous edge
    ack_after_request: assert property (
        @(posedge i_clock) disable iff (i_reset) o_wb.ack |-> $past(i_wb.cyc && i_wb.stb)
    ) else begin
        $error("Wishbone ack without a request");
        failures++;
    end

    output_holds_on_stall: assert property (
        @(posedge i_clock) disable iff (i_reset) !i_ready |=> $stable(o_sample)
    ) else begin
        $error("Output sample changed while stalled");
        failures++;
    end

    ready_passthrough: assert property (
        @(posedge i_clock) o_ready == i_ready
    ) else begin
        $error("o_ready differs from i_ready");
        failures++;
    end

endmodule

bind chmod_top chmod_sva u_chmod_sva (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_ready (i_ready),
    .o_ready (o_ready),
    .i_wb    (i_wb),
    .o_wb    (o_wb),
    .o_sample(o_sample)
);

// ==== verif/chmod_tb.sv ====
`timescale 1ns/1ps

module chmod_tb;
    import chmod_pkg::*;

    localparam real CLOCK_PERIOD = 10.0;
    localparam real PI = 3.14159265358979;
    localparam int DRIVE_DELAY = 1;
    localparam int PIPE_DEPTH = 4;
    localparam int BUS_TIMEOUT = 20;
    localparam int PASS_SAMPLES = 100;
    localparam int ROTATE_SAMPLES = 200;
    localparam int STALL_SAMPLES = 200;
    localparam int CLAMP_SAMPLES = 20;
    // Stalls may double the stall test; the rest covers bus traffic and resets
    localparam int WATCHDOG_CYCLES = 2 * (PASS_SAMPLES + ROTATE_SAMPLES + 2 * STALL_SAMPLES
                                          + 2 * CLAMP_SAMPLES) + 520;

    logic        clock;
    logic        reset;
    logic        ready;
    logic        ready_out;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    iq_sample_t  samples [NUM_CHANNELS];
    iq_sample_t  out_sample;

    // Reference model state
    logic signed [TRIG_WIDTH-1:0] ref_table [TABLE_DEPTH];
    logic [PHASE_WIDTH-1:0]       ref_acc [NUM_CHANNELS];
    logic [PHASE_WIDTH-1:0]       ref_inc [NUM_CHANNELS];
    logic signed [TRIG_WIDTH-1:0] ref_cos [NUM_CHANNELS];
    logic signed [TRIG_WIDTH-1:0] ref_sin [NUM_CHANNELS];
    logic                         ref_ack;
    logic                         ref_load;
    logic [CHAN_SEL_WIDTH-1:0]    ref_load_ch;
    logic [PHASE_WIDTH-1:0]       ref_load_inc;
    iq_sample_t                   expect_queue [$];
    iq_sample_t                   expected;

    int data_errors;
    int bus_errors;
    int seed;

    chmod_top u_chmod_top (
        .i_clock  (clock),
        .i_reset  (reset),
        .i_wb     (wb_req),
        .o_wb     (wb_rsp),
        .i_samples(samples),
        .o_ready  (ready_out),
        .o_sample (out_sample),
        .i_ready  (ready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        real amplitude;
        int entry;
        amplitude = real'(2 ** TRIG_SHIFT - 1);
        for (int k = 0; k < TABLE_DEPTH; k++) begin
            entry = $rtoi($floor(amplitude * $cos(k * PI / (2.0 * (TABLE_DEPTH - 1))) + 0.5));
            ref_table[k] = TRIG_WIDTH'(entry);
        end
    end

    function automatic logic signed [TRIG_WIDTH-1:0] model_cosine(
        input logic [1:0]                   quarter,
        input logic [TABLE_INDEX_WIDTH-1:0] k
    );
        int far_index;
        far_index = TABLE_DEPTH - 1 - int'(k);
        case (quarter)
            2'd0:    return ref_table[k];
            2'd1:    return -ref_table[far_index];
            2'd2:    return -ref_table[k];
            default: return ref_table[far_index];
        endcase
    endfunction

    function automatic logic signed [SAMPLE_WIDTH-1:0] scale_product(input longint value);
        longint shifted;
        shifted = value >>> TRIG_SHIFT;
        return SAMPLE_WIDTH'(shifted);
    endfunction

    function automatic logic signed [SAMPLE_WIDTH-1:0] clamp_sum(input int value);
        if (value > SAMPLE_MAX) begin
            return SAMPLE_WIDTH'(SAMPLE_MAX);
        end else if (value < SAMPLE_MIN) begin
            return SAMPLE_WIDTH'(SAMPLE_MIN);
        end
        return SAMPLE_WIDTH'(value);
    endfunction

    function automatic iq_sample_t mix_sample(
        input iq_sample_t                   s,
        input logic signed [TRIG_WIDTH-1:0] c,
        input logic signed [TRIG_WIDTH-1:0] sn
    );
        longint inph_prod;
        longint quad_prod;
        iq_sample_t result;
        inph_prod = longint'($signed(s.inph)) * longint'(c)
                    - longint'($signed(s.quad)) * longint'(sn);
        quad_prod = longint'($signed(s.inph)) * longint'(sn)
                    + longint'($signed(s.quad)) * longint'(c);
        result.inph = scale_product(inph_prod);
        result.quad = scale_product(quad_prod);
        return result;
    endfunction

    // Model steps on the same edges as the DUT
    always @(posedge clock) begin : model_step
        iq_sample_t mixed;
        iq_sample_t combined;
        int inph_total;
        int quad_total;
        logic [TABLE_PHASE_WIDTH-1:0] tphase;
        logic bus_req;
        if (reset) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                ref_acc[ch] = '0;
                ref_inc[ch] = '0;
                ref_cos[ch] = '0;
                ref_sin[ch] = '0;
            end
            ref_ack = 1'b0;
            ref_load = 1'b0;
            expect_queue = {};
            repeat (PIPE_DEPTH) expect_queue.push_back('0);
            expected = '0;
        end else begin
            if (ready) begin
                inph_total = 0;
                quad_total = 0;
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    mixed = mix_sample(samples[ch], ref_cos[ch], ref_sin[ch]);
                    inph_total += int'($signed(mixed.inph));
                    quad_total += int'($signed(mixed.quad));
                    tphase = ref_acc[ch][PHASE_WIDTH-1 -: TABLE_PHASE_WIDTH];
                    ref_cos[ch] = model_cosine(tphase[7:6], tphase[5:0]);
                    ref_sin[ch] = model_cosine(tphase[7:6] - 2'd1, tphase[5:0]);
                    ref_acc[ch] = ref_acc[ch] + ref_inc[ch];
                end
                combined.inph = clamp_sum(inph_total);
                combined.quad = clamp_sum(quad_total);
                expect_queue.push_back(combined);
                expected = expect_queue.pop_front();
            end
            if (ref_load) begin
                ref_inc[ref_load_ch] = ref_load_inc;
            end
            bus_req = wb_req.cyc && wb_req.stb && !ref_ack;
            ref_load = bus_req && wb_req.we;
            ref_load_ch = wb_req.adr;
            ref_load_inc = wb_req.dat[PHASE_WIDTH-1:0];
            ref_ack = bus_req;
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            assert (out_sample == expected) else begin
                $display("CHECK FAILED at %0t: output %h/%h, expected %h/%h", $time,
                         out_sample.inph, out_sample.quad, expected.inph, expected.quad);
                data_errors++;
            end
            assert (wb_rsp.ack == ref_ack) else begin
                $display("CHECK FAILED at %0t: ack %b, expected %b", $time, wb_rsp.ack, ref_ack);
                bus_errors++;
            end
        end
    end

    task automatic apply_reset();
        @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    task automatic bus_access(
        input  logic                      write,
        input  int                        ch,
        input  logic [WB_DATA_WIDTH-1:0]  data,
        output logic [WB_DATA_WIDTH-1:0]  read_data
    );
        int waited;
        @(posedge clock);
        #DRIVE_DELAY;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = write;
        wb_req.adr = CHAN_SEL_WIDTH'(ch);
        wb_req.dat = data;
        waited = 0;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
        end while (!wb_rsp.ack && waited < BUS_TIMEOUT);
        if (!wb_rsp.ack) begin
            $display("Wishbone access to channel %0d was never acknowledged", ch);
            bus_errors++;
        end
        read_data = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic write_increment(input int ch, input logic [WB_DATA_WIDTH-1:0] data);
        logic [WB_DATA_WIDTH-1:0] unused;
        bus_access(1'b1, ch, data, unused);
    endtask

    task automatic check_readback(input int ch, input logic [WB_DATA_WIDTH-1:0] written);
        logic [WB_DATA_WIDTH-1:0] read_data;
        bus_access(1'b0, ch, '0, read_data);
        assert (read_data == {20'd0, written[PHASE_WIDTH-1:0]}) else begin
            $display("CHECK FAILED at %0t: channel %0d read %h, wrote %h", $time, ch,
                     read_data, written);
            bus_errors++;
        end
    endtask

    task automatic stream_samples(input int count, input bit with_stalls);
        int accepted;
        int stall_left;
        accepted = 0;
        stall_left = 0;
        while (accepted < count) begin
            @(posedge clock);
            if (ready) begin
                accepted++;
            end
            #DRIVE_DELAY;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                samples[ch].inph = SAMPLE_WIDTH'($random(seed));
                samples[ch].quad = SAMPLE_WIDTH'($random(seed));
            end
            if (with_stalls && stall_left == 0 && ($random(seed) & 3) == 0) begin
                stall_left = 1 + ($random(seed) & 7);
            end
            if (stall_left > 0) begin
                ready = 1'b0;
                stall_left--;
            end else begin
                ready = 1'b1;
            end
        end
        ready = 1'b1;
    endtask

    task automatic drive_constant(input iq_sample_t value, input int count);
        repeat (count) begin
            @(posedge clock);
            #DRIVE_DELAY;
            ready = 1'b1;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                samples[ch] = value;
            end
        end
    endtask

    task automatic check_clamp(input logic signed [SAMPLE_WIDTH-1:0] limit);
        @(negedge clock);
        assert (out_sample.inph == limit && out_sample.quad == limit) else begin
            $display("CHECK FAILED at %0t: clamp gave %h/%h, expected %h", $time,
                     out_sample.inph, out_sample.quad, limit);
            data_errors++;
        end
    endtask

    initial begin
        reset = 1'b1;
        ready = 1'b0;
        wb_req = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            samples[ch] = '0;
        end
        data_errors = 0;
        bus_errors = 0;
        seed = 41;
        apply_reset();
        repeat (4) @(posedge clock);

        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            write_increment(ch, 32'hABCD_E000 | (32'h5A1 + 32'(ch * 291)));
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_readback(ch, 32'hABCD_E000 | (32'h5A1 + 32'(ch * 291)));
        end

        // Zero increments hold the oscillators at phase zero
        apply_reset();
        stream_samples(PASS_SAMPLES, 1'b0);

        write_increment(0, 32'd1024);
        write_increment(1, 32'd2048);
        write_increment(2, 32'd512);
        write_increment(3, 32'd3);
        stream_samples(ROTATE_SAMPLES, 1'b0);
        stream_samples(STALL_SAMPLES, 1'b1);
        stream_samples(PIPE_DEPTH + 2, 1'b0);

        apply_reset();
        drive_constant('{inph: 16'sh7FFF, quad: 16'sh7FFF}, CLAMP_SAMPLES);
        check_clamp(16'sh7FFF);
        drive_constant('{inph: 16'sh8000, quad: 16'sh8000}, CLAMP_SAMPLES);
        check_clamp(16'sh8000);

        $display("Run complete: %0d data errors, %0d bus errors, %0d assertion failures",
                 data_errors, bus_errors, u_chmod_top.u_chmod_sva.failures);
        if (data_errors + bus_errors + u_chmod_top.u_chmod_sva.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: simulation did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== source/chmod_cos_table.mem ====
// Cosine quarter wave, entry k = round(131071 * cos(k * pi / 128)), 18-bit hex
1FFFF
1FFD8
1FF61
1FE9C
1FD88
1FC25
1FA74
1F875
1F629
1F38E
1F0A7
1ED73
1E9F3
1E628
1E211
1DDB0
1D906
1D412
1CED7
1C954
1C38A
1BD7B
1B727
1B090
1A9B6
1A29A
19B3D
193A1
18BC7
183B0
17B5D
172D0
16A09
1610B
157D6
14E6C
144CF
13AFF
130FF
126D0
11C73
111EB
10738
0FC5D
0F15A
0E633
0DAE8
0CF7B
0C3EF
0B844
0AC7C
0A09B
094A0
0888E
07C68
0702E
063E3
05788
04B20
03EAC
0322F
025AA
0191F
00C91
00000

// ==== filelist.f ====
source/chmod_pkg.sv
source/chmod_dds.sv
source/channel_modulator.sv
source/chmod_wb_regs.sv
source/chmod_combiner.sv
source/chmod_top.sv
verif/chmod_sva.sv
verif/chmod_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := chmod_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
